/* apb_slave_pkg.sv */
//--------------------------------------------------------------------------
// Shared definitions for the APB memory slave: address map, widths,
// function register offsets and the function write word union
//--------------------------------------------------------------------------
`default_nettype none

package apb_slave_pkg;

    // Bus widths
    localparam int ADDR_W     = 10;
    localparam int DATA_W     = 32;
    localparam int WORD_BYTES = DATA_W / 8;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;

    // Memory occupies the bottom of the address space
    localparam int MEM_BYTES = 512;
    localparam int MEM_AW    = $clog2(MEM_BYTES);

    // Function space, 256 bytes from FUNC_BASE
    localparam addr_t FUNC_BASE = 10'h200;

    // Byte offsets inside the function space
    localparam logic [7:0] FUNC_ERR_OFS   = 8'd0;
    localparam logic [7:0] FUNC_WAIT_OFS  = 8'd4;
    localparam logic [7:0] FUNC_LADDR_OFS = 8'd44;
    localparam logic [7:0] FUNC_LDATA_OFS = 8'd48;

    // Wait count width, only the low byte of the old setting survives
    localparam int WAIT_W = 8;

    //----------------------------------------------------------------------
    // Function register write word
    //----------------------------------------------------------------------
    typedef struct packed {
        logic [23:0] rsvd;
        logic [7:0]  count;
    } func_err_t;

    typedef struct packed {
        logic [23:0]       rsvd;
        logic [WAIT_W-1:0] cycles;
    } func_wait_t;

    // Same PWDATA word, read as error count or as wait count
    typedef union packed {
        func_err_t  err_view;
        func_wait_t wait_view;
    } func_word_u;

endpackage : apb_slave_pkg

`default_nettype wire

/* apb_access_decode.sv */
//--------------------------------------------------------------------------
// APB phase tracking, wait-state counter, PREADY and access strobes
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module apb_access_decode (
    input  logic                             PCLK,
    input  logic                             PRESETN,
    input  logic                             psel,
    input  logic                             penable,
    input  logic                             pwrite,
    input  apb_slave_pkg::addr_t             paddr,
    input  logic [apb_slave_pkg::WAIT_W-1:0] wait_cycles,
    output logic                             pready,
    output logic                             issue,
    output logic                             mem_wr,
    output logic                             func_wr,
    output logic                             rd_capture,
    output logic                             rd_func,
    output apb_slave_pkg::addr_t             word_addr,
    output logic [7:0]                       func_ofs
);
    import apb_slave_pkg::*;

    logic              setup_ph;
    logic              access_ph;
    logic              complete;
    logic              is_mem;
    logic              is_func;
    logic [WAIT_W-1:0] wait_cnt_q;

    assign setup_ph  = psel & ~penable;
    assign access_ph = psel & penable;

    //----------------------------------------------------------------------
    // Address classes
    //----------------------------------------------------------------------
    assign word_addr = {paddr[ADDR_W-1:2], 2'b00};
    assign func_ofs  = word_addr[7:0];

    assign is_mem  = (word_addr < addr_t'(MEM_BYTES));
    // Function space is one 256-byte page
    assign is_func = (word_addr[ADDR_W-1:8] == FUNC_BASE[ADDR_W-1:8]);
    assign rd_func = is_func;

    //----------------------------------------------------------------------
    // Wait states and PREADY
    //----------------------------------------------------------------------
    // Zero wait states issue straight from the setup cycle
    assign issue = (setup_ph & (wait_cycles == '0))
                 | (access_ph & ~pready & (wait_cnt_q == '0));

    always_ff @(posedge PCLK or negedge PRESETN)
    begin
        if (!PRESETN)
        begin
            wait_cnt_q <= '0;
            pready     <= 1'b0;
        end
        else
        begin
            pready <= issue;
            // Setup edge counts as the first wait cycle
            if (setup_ph)
            begin
                wait_cnt_q <= wait_cycles - WAIT_W'(1);
            end
            else if (access_ph && (wait_cnt_q != '0))
            begin
                wait_cnt_q <= wait_cnt_q - WAIT_W'(1);
            end
        end
    end

    // Completion strobes
    assign complete   = access_ph & pready;
    assign mem_wr     = complete & pwrite & is_mem;
    assign func_wr    = complete & pwrite & is_func;
    // Unmapped reads get no capture and return zero
    assign rd_capture = issue & ~pwrite & (is_mem | is_func);

    //----------------------------------------------------------------------
    // Master protocol checks
    //----------------------------------------------------------------------
    a_enable_needs_sel : assert property (@(posedge PCLK) disable iff (!PRESETN)
        penable |-> psel);

    a_access_stable : assert property (@(posedge PCLK) disable iff (!PRESETN)
        (psel && penable) |-> ($stable(paddr) && $stable(pwrite)));

endmodule : apb_access_decode

`default_nettype wire

/* apb_mem_execute.sv */
//--------------------------------------------------------------------------
// Byte memory with APB and extension port write and read paths
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module apb_mem_execute (
    input  logic                 PCLK,
    input  logic                 PRESETN,
    input  logic                 mem_wr,
    input  apb_slave_pkg::addr_t word_addr,
    input  apb_slave_pkg::data_t pwdata,
    input  logic                 ext_en,
    input  logic                 ext_wr,
    input  logic                 ext_rd,
    input  apb_slave_pkg::addr_t ext_addr,
    input  apb_slave_pkg::data_t ext_wdata,
    output apb_slave_pkg::data_t mem_rdata,
    output apb_slave_pkg::data_t ext_rdata
);
    import apb_slave_pkg::*;

    logic [7:0]        mem_q [MEM_BYTES];
    logic [MEM_AW-1:0] apb_base;
    logic [MEM_AW-1:0] ext_base;
    logic              ext_in_mem;

    // Word base addresses, low two bits dropped
    assign apb_base   = {word_addr[MEM_AW-1:2], 2'b00};
    assign ext_base   = {ext_addr[MEM_AW-1:2], 2'b00};
    assign ext_in_mem = (ext_addr < addr_t'(MEM_BYTES));

    // Little-endian word, byte 0 at the lowest address
    function automatic data_t read_word(input logic [MEM_AW-1:0] base);
        data_t word;
        for (int i = 0; i < WORD_BYTES; i++)
        begin
            word[8*i +: 8] = mem_q[base + MEM_AW'(i)];
        end
        return word;
    endfunction

    //----------------------------------------------------------------------
    // Write paths
    //----------------------------------------------------------------------
    always_ff @(posedge PCLK)
    begin
        if (mem_wr)
        begin
            for (int i = 0; i < WORD_BYTES; i++)
            begin
                mem_q[apb_base + MEM_AW'(i)] <= pwdata[8*i +: 8];
            end
        end
        // Extension write comes last so it wins a same-word clash
        if (ext_en && ext_wr && ext_in_mem)
        begin
            for (int i = 0; i < WORD_BYTES; i++)
            begin
                mem_q[ext_base + MEM_AW'(i)] <= ext_wdata[8*i +: 8];
            end
        end
    end

    //----------------------------------------------------------------------
    // Read paths
    //----------------------------------------------------------------------
    // APB side is combinational, result block captures it
    assign mem_rdata = read_word(apb_base);

    // Extension read data lives for one cycle only
    always_ff @(posedge PCLK or negedge PRESETN)
    begin
        if (!PRESETN)
        begin
            ext_rdata <= '0;
        end
        else if (ext_en && ext_rd && ext_in_mem)
        begin
            ext_rdata <= read_word(ext_base);
        end
        else
        begin
            ext_rdata <= '0;
        end
    end

endmodule : apb_mem_execute

`default_nettype wire

/* apb_func_regs.sv */
//--------------------------------------------------------------------------
// Error injection, wait configuration and last-access registers
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module apb_func_regs (
    input  logic                             PCLK,
    input  logic                             PRESETN,
    input  logic                             func_wr,
    input  logic                             mem_wr,
    input  logic                             rd_capture,
    input  logic                             rd_func,
    input  logic                             issue,
    input  logic [7:0]                       func_ofs,
    input  apb_slave_pkg::addr_t             word_addr,
    input  apb_slave_pkg::data_t             pwdata,
    input  apb_slave_pkg::data_t             mem_rdata,
    output logic [apb_slave_pkg::WAIT_W-1:0] wait_cycles,
    output logic                             err_fire,
    output apb_slave_pkg::data_t             func_rdata
);
    import apb_slave_pkg::*;

    func_word_u        wdata_u;
    logic              err_armed_q;
    logic [7:0]        err_cnt_q;
    logic [WAIT_W-1:0] wait_q;
    addr_t             last_addr_q;
    data_t             last_data_q;

    assign wdata_u     = pwdata;
    assign wait_cycles = wait_q;

    // Count of 1 or 0 means this access takes the error
    assign err_fire = err_armed_q & (err_cnt_q <= 8'd1);

    //----------------------------------------------------------------------
    // Control registers
    //----------------------------------------------------------------------
    always_ff @(posedge PCLK or negedge PRESETN)
    begin
        if (!PRESETN)
        begin
            err_armed_q <= 1'b0;
            err_cnt_q   <= '0;
            wait_q      <= '0;
        end
        else
        begin
            if (func_wr && (func_ofs == FUNC_ERR_OFS))
            begin
                err_armed_q <= 1'b1;
                err_cnt_q   <= wdata_u.err_view.count;
            end
            else if (issue && err_armed_q)
            begin
                if (err_cnt_q <= 8'd1)
                    err_armed_q <= 1'b0;
                else
                    err_cnt_q <= err_cnt_q - 8'd1;
            end

            if (func_wr && (func_ofs == FUNC_WAIT_OFS))
            begin
                wait_q <= wdata_u.wait_view.cycles;
            end
        end
    end

    // Last memory access, function space accesses leave it alone
    always_ff @(posedge PCLK)
    begin
        if (mem_wr)
        begin
            last_addr_q <= word_addr;
            last_data_q <= pwdata;
        end
        else if (rd_capture && !rd_func)
        begin
            last_addr_q <= word_addr;
            last_data_q <= mem_rdata;
        end
    end

    // Readback mux
    always_comb
    begin
        case (func_ofs)
            FUNC_LADDR_OFS : func_rdata = DATA_W'(last_addr_q);
            FUNC_LDATA_OFS : func_rdata = last_data_q;
            default        : func_rdata = '0;
        endcase
    end

endmodule : apb_func_regs

`default_nettype wire

/* apb_read_result.sv */
//--------------------------------------------------------------------------
// PRDATA capture and gating, PSLVERR timing
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module apb_read_result (
    input  logic                 PCLK,
    input  logic                 PRESETN,
    input  logic                 issue,
    input  logic                 rd_capture,
    input  logic                 rd_func,
    input  logic                 penable,
    input  logic                 pready,
    input  logic                 err_fire,
    input  apb_slave_pkg::data_t mem_rdata,
    input  apb_slave_pkg::data_t func_rdata,
    output apb_slave_pkg::data_t prdata,
    output logic                 pslverr
);
    import apb_slave_pkg::*;

    data_t prdata_q;

    // Response flag lines up with PREADY
    always_ff @(posedge PCLK or negedge PRESETN)
    begin
        if (!PRESETN)
            pslverr <= 1'b0;
        else
            pslverr <= issue & err_fire;
    end

    // Read word, zero for writes and unmapped reads
    always_ff @(posedge PCLK)
    begin
        if (issue)
        begin
            if (rd_capture)
                prdata_q <= rd_func ? func_rdata : mem_rdata;
            else
                prdata_q <= '0;
        end
    end

    assign prdata = penable ? prdata_q : '0;

    a_err_with_ready : assert property (@(posedge PCLK) disable iff (!PRESETN)
        pslverr |-> pready);

endmodule : apb_read_result

`default_nettype wire

/* apb_slave_mem.sv */
//--------------------------------------------------------------------------
// APB memory slave top level with extension port
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module apb_slave_mem (
    input  logic                 PCLK,
    input  logic                 PRESETN,
    // APB
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  apb_slave_pkg::addr_t paddr,
    input  apb_slave_pkg::data_t pwdata,
    output apb_slave_pkg::data_t prdata,
    output logic                 pready,
    output logic                 pslverr,
    // Extension port
    input  logic                 ext_en,
    input  logic                 ext_wr,
    input  logic                 ext_rd,
    input  apb_slave_pkg::addr_t ext_addr,
    input  apb_slave_pkg::data_t ext_wdata,
    output apb_slave_pkg::data_t ext_rdata
);
    import apb_slave_pkg::*;

    logic              issue;
    logic              mem_wr;
    logic              func_wr;
    logic              rd_capture;
    logic              rd_func;
    addr_t             word_addr;
    logic [7:0]        func_ofs;
    logic [WAIT_W-1:0] wait_cycles;
    logic              err_fire;
    data_t             mem_rdata;
    data_t             func_rdata;

    apb_access_decode decode_i (
        .PCLK        (PCLK),
        .PRESETN     (PRESETN),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .wait_cycles (wait_cycles),
        .pready      (pready),
        .issue       (issue),
        .mem_wr      (mem_wr),
        .func_wr     (func_wr),
        .rd_capture  (rd_capture),
        .rd_func     (rd_func),
        .word_addr   (word_addr),
        .func_ofs    (func_ofs)
    );

    apb_mem_execute mem_i (
        .PCLK      (PCLK),
        .PRESETN   (PRESETN),
        .mem_wr    (mem_wr),
        .word_addr (word_addr),
        .pwdata    (pwdata),
        .ext_en    (ext_en),
        .ext_wr    (ext_wr),
        .ext_rd    (ext_rd),
        .ext_addr  (ext_addr),
        .ext_wdata (ext_wdata),
        .mem_rdata (mem_rdata),
        .ext_rdata (ext_rdata)
    );

    apb_func_regs regs_i (
        .PCLK        (PCLK),
        .PRESETN     (PRESETN),
        .func_wr     (func_wr),
        .mem_wr      (mem_wr),
        .rd_capture  (rd_capture),
        .rd_func     (rd_func),
        .issue       (issue),
        .func_ofs    (func_ofs),
        .word_addr   (word_addr),
        .pwdata      (pwdata),
        .mem_rdata   (mem_rdata),
        .wait_cycles (wait_cycles),
        .err_fire    (err_fire),
        .func_rdata  (func_rdata)
    );

    apb_read_result result_i (
        .PCLK       (PCLK),
        .PRESETN    (PRESETN),
        .issue      (issue),
        .rd_capture (rd_capture),
        .rd_func    (rd_func),
        .penable    (penable),
        .pready     (pready),
        .err_fire   (err_fire),
        .mem_rdata  (mem_rdata),
        .func_rdata (func_rdata),
        .prdata     (prdata),
        .pslverr    (pslverr)
    );

endmodule : apb_slave_mem

`default_nettype wire

/* tb_apb_slave_mem.sv */
//--------------------------------------------------------------------------
// Testbench for the APB memory slave: clock, reset, APB and extension
// port tasks, directed tests and watchdog
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module tb_apb_slave_mem;
    import apb_slave_pkg::*;

    localparam int CLK_HALF     = 10;
    localparam int DRIVE_DLY    = 2;
    localparam int RESET_CYCLES = 10;
    localparam int XFER_LIMIT   = 64;
    // About 60 transfers of up to 7 cycles plus reset, with wide margin
    localparam int WATCHDOG_CYCLES = 2000;

    logic   PCLK;
    logic   PRESETN;
    logic   psel;
    logic   penable;
    logic   pwrite;
    addr_t  paddr;
    data_t  pwdata;
    data_t  prdata;
    logic   pready;
    logic   pslverr;
    logic   ext_en;
    logic   ext_wr;
    logic   ext_rd;
    addr_t  ext_addr;
    data_t  ext_wdata;
    data_t  ext_rdata;

    // Expected memory contents, one entry per word
    data_t  model_mem [MEM_BYTES/4];
    addr_t  word_list [16];
    integer seed;

    apb_slave_mem dut_i (
        .PCLK      (PCLK),
        .PRESETN   (PRESETN),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .ext_en    (ext_en),
        .ext_wr    (ext_wr),
        .ext_rd    (ext_rd),
        .ext_addr  (ext_addr),
        .ext_wdata (ext_wdata),
        .ext_rdata (ext_rdata)
    );

    initial
    begin
        PCLK = 1'b0;
        forever #CLK_HALF PCLK = ~PCLK;
    end

    //----------------------------------------------------------------------
    // Failure reporting
    //----------------------------------------------------------------------
    task automatic stop_run();
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input data_t expected,
                                   input data_t actual);
        $display("Error at %0t: %s expected 0x%h, got 0x%h", $time, name, expected, actual);
        stop_run();
    endtask

    task automatic report_failure(input string why);
        $display("%s (at %0t)", why, $time);
        stop_run();
    endtask

    // Sampled mid-cycle while no transfer is in flight
    task automatic check_quiet_outputs();
        assert (pready == 1'b0) else report_mismatch("pready", 0, data_t'(pready));
        assert (pslverr == 1'b0) else report_mismatch("pslverr", 0, data_t'(pslverr));
        assert (prdata == '0) else report_mismatch("prdata", 0, prdata);
        assert (ext_rdata == '0) else report_mismatch("ext_rdata", 0, ext_rdata);
    endtask

    //----------------------------------------------------------------------
    // APB master
    //----------------------------------------------------------------------
    // Called 2 ns after a rising edge, returns at the same point
    task automatic apb_transfer(input logic wr, input addr_t addr, input data_t wdata,
                                output data_t rdata, output logic err, output int cycles);
        logic done;
        done    = 1'b0;
        rdata   = '0;
        err     = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        cycles  = 1;
        @(negedge PCLK);
        check_quiet_outputs();
        @(posedge PCLK);
        #DRIVE_DLY;
        penable = 1'b1;
        while (!done)
        begin
            cycles++;
            @(negedge PCLK);
            if (pready)
            begin
                rdata = prdata;
                err   = pslverr;
                done  = 1'b1;
            end
            else
            begin
                assert (pslverr == 1'b0) else report_mismatch("pslverr", 0, data_t'(pslverr));
                if (cycles > XFER_LIMIT)
                    report_failure("Timeout: PREADY never rose during an APB transfer");
            end
            @(posedge PCLK);
            #DRIVE_DLY;
        end
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        // PREADY must already be gone again
        @(negedge PCLK);
        check_quiet_outputs();
        @(posedge PCLK);
        #DRIVE_DLY;
    endtask

    task automatic apb_write(input addr_t addr, input data_t wdata,
                             output logic err, output int cycles);
        data_t unused_rdata;
        apb_transfer(1'b1, addr, wdata, unused_rdata, err, cycles);
        if (addr < addr_t'(MEM_BYTES))
            model_mem[addr[8:2]] = wdata;
    endtask

    task automatic apb_read(input addr_t addr, output data_t rdata,
                            output logic err, output int cycles);
        apb_transfer(1'b0, addr, '0, rdata, err, cycles);
    endtask

    task automatic read_and_compare(input addr_t addr, input data_t expected);
        data_t rdata;
        logic  err;
        int    cycles;
        apb_read(addr, rdata, err, cycles);
        assert (rdata == expected) else report_mismatch("prdata", expected, rdata);
        assert (err == 1'b0) else report_mismatch("pslverr", 0, data_t'(err));
    endtask

    //----------------------------------------------------------------------
    // Extension port
    //----------------------------------------------------------------------
    task automatic ext_write(input addr_t addr, input data_t wdata);
        ext_en    = 1'b1;
        ext_wr    = 1'b1;
        ext_addr  = addr;
        ext_wdata = wdata;
        @(posedge PCLK);
        #DRIVE_DLY;
        ext_en = 1'b0;
        ext_wr = 1'b0;
        if (addr < addr_t'(MEM_BYTES))
            model_mem[addr[8:2]] = wdata;
    endtask

    // Returns the word seen one cycle after the strobe edge
    task automatic ext_read(input addr_t addr, output data_t rdata);
        ext_en   = 1'b1;
        ext_rd   = 1'b1;
        ext_addr = addr;
        @(negedge PCLK);
        assert (ext_rdata == '0) else report_mismatch("ext_rdata", 0, ext_rdata);
        @(posedge PCLK);
        #DRIVE_DLY;
        ext_en = 1'b0;
        ext_rd = 1'b0;
        @(negedge PCLK);
        rdata = ext_rdata;
        @(posedge PCLK);
        #DRIVE_DLY;
    endtask

    //----------------------------------------------------------------------
    // Directed tests
    //----------------------------------------------------------------------
    task automatic reset_idle_check();
        PRESETN = 1'b0;
        repeat (RESET_CYCLES)
        begin
            @(negedge PCLK);
            check_quiet_outputs();
            @(posedge PCLK);
        end
        #DRIVE_DLY;
        PRESETN = 1'b1;
        repeat (3)
        begin
            @(negedge PCLK);
            check_quiet_outputs();
        end
        @(posedge PCLK);
        #DRIVE_DLY;
    endtask

    task automatic memory_word_test();
        data_t rdata;
        logic  err;
        int    cycles;
        int    ofs;
        for (int i = 0; i < 16; i++)
        begin
            ofs = ($random(seed) & 7) * 4;
            word_list[i] = addr_t'(i * 32 + ofs);
            apb_write(word_list[i], $random(seed), err, cycles);
            assert (cycles == 2) else report_mismatch("write cycles", 2, cycles);
            assert (err == 1'b0) else report_mismatch("pslverr", 0, data_t'(err));
        end
        for (int i = 0; i < 16; i++)
        begin
            apb_read(word_list[i], rdata, err, cycles);
            assert (rdata == model_mem[word_list[i][8:2]])
                else report_mismatch("prdata", model_mem[word_list[i][8:2]], rdata);
            assert (cycles == 2) else report_mismatch("read cycles", 2, cycles);
        end
    endtask

    task automatic wait_state_test();
        data_t rdata;
        logic  err;
        int    cycles;
        apb_write(FUNC_BASE + addr_t'(FUNC_WAIT_OFS), 32'd3, err, cycles);
        assert (cycles == 2) else report_mismatch("write cycles", 2, cycles);
        for (int i = 0; i < 3; i++)
        begin
            apb_read(word_list[i], rdata, err, cycles);
            assert (cycles == 5) else report_mismatch("read cycles", 5, cycles);
            assert (rdata == model_mem[word_list[i][8:2]])
                else report_mismatch("prdata", model_mem[word_list[i][8:2]], rdata);
        end
        apb_write(word_list[3], $random(seed), err, cycles);
        assert (cycles == 5) else report_mismatch("write cycles", 5, cycles);
        // Back to zero wait, this write still sees three
        apb_write(FUNC_BASE + addr_t'(FUNC_WAIT_OFS), 32'd0, err, cycles);
        assert (cycles == 5) else report_mismatch("write cycles", 5, cycles);
        apb_read(word_list[3], rdata, err, cycles);
        assert (cycles == 2) else report_mismatch("read cycles", 2, cycles);
        assert (rdata == model_mem[word_list[3][8:2]])
            else report_mismatch("prdata", model_mem[word_list[3][8:2]], rdata);
    endtask

    task automatic error_injection_test();
        data_t rdata;
        logic  err;
        int    cycles;
        logic  expect_err;
        apb_write(FUNC_BASE + addr_t'(FUNC_ERR_OFS), 32'd3, err, cycles);
        assert (err == 1'b0) else report_mismatch("pslverr", 0, data_t'(err));
        for (int i = 0; i < 6; i++)
        begin
            expect_err = (i == 2);
            apb_read(word_list[i], rdata, err, cycles);
            assert (err == expect_err)
                else report_mismatch("pslverr", data_t'(expect_err), data_t'(err));
        end
    endtask

    task automatic last_access_test();
        addr_t a_addr;
        addr_t b_addr;
        data_t d_word;
        logic  err;
        int    cycles;
        a_addr = 10'h0C4;
        d_word = $random(seed);
        apb_write(a_addr, d_word, err, cycles);
        read_and_compare(FUNC_BASE + addr_t'(FUNC_LADDR_OFS), data_t'(a_addr));
        read_and_compare(FUNC_BASE + addr_t'(FUNC_LDATA_OFS), d_word);
        b_addr = word_list[9];
        read_and_compare(b_addr, model_mem[b_addr[8:2]]);
        read_and_compare(FUNC_BASE + addr_t'(FUNC_LADDR_OFS), data_t'(b_addr));
        read_and_compare(FUNC_BASE + addr_t'(FUNC_LDATA_OFS), model_mem[b_addr[8:2]]);
    endtask

    task automatic extension_port_test();
        data_t word;
        data_t rdata;
        logic  err;
        int    cycles;
        word = $random(seed);
        ext_write(10'h100, word);
        read_and_compare(10'h100, word);
        word = $random(seed);
        apb_write(10'h1F0, word, err, cycles);
        ext_read(10'h1F0, rdata);
        assert (rdata == word) else report_mismatch("ext_rdata", word, rdata);
        @(negedge PCLK);
        assert (ext_rdata == '0) else report_mismatch("ext_rdata", 0, ext_rdata);
        @(posedge PCLK);
        #DRIVE_DLY;
    endtask

    //----------------------------------------------------------------------
    // Main sequence and watchdog
    //----------------------------------------------------------------------
    initial
    begin
        seed      = 67;
        PRESETN   = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        ext_en    = 1'b0;
        ext_wr    = 1'b0;
        ext_rd    = 1'b0;
        ext_addr  = '0;
        ext_wdata = '0;
        reset_idle_check();
        memory_word_test();
        wait_state_test();
        error_injection_test();
        last_access_test();
        extension_port_test();
        $display("No errors");
        $finish;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge PCLK);
        report_failure("Watchdog expired before the tests finished");
    end

endmodule : tb_apb_slave_mem

`default_nettype wire

/* apb_slave_mem.f */
apb_slave_pkg.sv
apb_access_decode.sv
apb_mem_execute.sv
apb_func_regs.sv
apb_read_result.sv
apb_slave_mem.sv
tb_apb_slave_mem.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the APB memory slave testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_apb_slave_mem -f apb_slave_mem.f -o sim_apb_slave_mem \
    && ./obj_dir/sim_apb_slave_mem \
    || { echo "Simulation run FAILED"; exit 1; }
